// File: list.f
hdl/mipsPkg.sv
hdl/decodeCtrl.sv
hdl/regFile.sv
hdl/operandPrep.sv
hdl/branchUnit.sv
hdl/decodeStage.sv
tests/decodeStage_props.sv
tests/decodeStage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module decodeStage_tb -f list.f -o simv
./obj_dir/simv

// File: tests/decodeStage_tb.sv
`timescale 1ns/1ps

module decodeStage_tb;

  import mipsPkg::*;

  logic                 clk;
  logic                 arstN;
  logic [dataWidth-1:0] instr;
  logic [dataWidth-1:0] pc4;
  stageInfo             memStage;
  stageInfo             wbStage;
  wbPort                wb;
  decodeOut             out;

  // What the register file should hold
  logic [dataWidth-1:0] regModel [0:31];
  logic [31:0]          lfsr;

  decodeStage i_decodeStage (
    .clk      (clk),
    .arstN    (arstN),
    .instr    (instr),
    .pc4      (pc4),
    .memStage (memStage),
    .wbStage  (wbStage),
    .wb       (wb),
    .out      (out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random fields
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR shifted once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] randInstr();
    logic [31:0] r;
    logic [31:0] k;
    logic [31:0] s;
    logic [5:0]  opc;
    logic [5:0]  fn;
    r  = randBits(32);
    k  = randBits(4);
    s  = randBits(2);
    fn = r[5:0];
    case (k[3:0])
      4'd0: begin
        opc = opcSpecial;
        fn  = fnAddu;
      end
      4'd1: begin
        opc = opcSpecial;
        fn  = fnSubu;
      end
      4'd2: begin
        opc = opcSpecial;
        fn  = fnJr;
      end
      4'd3:    opc = opcOri;
      4'd4:    opc = opcLui;
      4'd5:    opc = opcLw;
      4'd6:    opc = opcSw;
      4'd7:    opc = opcBeq;
      4'd8:    opc = opcBne;
      4'd9:    opc = opcJ;
      4'd10:   opc = opcJal;
      // Unknown opcode
      default: opc = 6'h3f;
    endcase
    // rt copies rs now and then so branches go both ways
    return {opc, r[25:21], (s[1:0] == 2'd0) ? r[25:21] : r[20:16], r[15:6], fn};
  endfunction

  // Dest hits rs or rt half the time
  function automatic stageInfo randStage(input logic [31:0] ins);
    stageInfo    s;
    logic [31:0] r;
    r       = randBits(11);
    s.valid = r[0] | r[1];
    s.isPc8 = r[2];
    s.isMem = r[3];
    case (r[5:4])
      2'd0:    s.dest = ins[25:21];
      2'd1:    s.dest = ins[20:16];
      default: s.dest = r[10:6];
    endcase
    s.alu   = randBits(32);
    s.other = randBits(32);
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference values
  //////////////////////////////////////////////////////////////////////

  // File read with same-cycle write passed through
  function automatic logic [31:0] fileRead(input logic [4:0] ra);
    if (ra == 5'd0) return '0;
    if (wb.writeEn && wb.addr == ra) return wb.data;
    return regModel[ra];
  endfunction

  // Memory beats writeback beats the file
  function automatic logic [31:0] operand(input logic [4:0] ra);
    if (ra != 5'd0 && memStage.valid && memStage.dest == ra)
      return memStage.isPc8 ? memStage.other : memStage.alu;
    if (ra != 5'd0 && wbStage.valid && wbStage.dest == ra)
      return wbStage.isMem ? wbStage.other : wbStage.alu;
    return fileRead(ra);
  endfunction

  task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("ERROR %s expected %h got %h", name, exp, got);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkOutputs();
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [15:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  a3Exp;
    logic        take;
    logic [31:0] tgt;
    opc   = instr[31:26];
    fn    = instr[5:0];
    imm   = instr[15:0];
    a     = operand(instr[25:21]);
    b     = operand(instr[20:16]);
    a3Exp = 5'd0;
    take  = 1'b0;
    tgt   = '0;
    expectEq("out.v1", a, out.v1);
    expectEq("out.v2", b, out.v2);
    expectEq("out.pc8", pc4 + 32'd4, out.pc8);
    if (opc == opcOri) expectEq("out.ext", {16'h0000, imm}, out.ext);
    else if (opc == opcLui) expectEq("out.ext", {imm, 16'h0000}, out.ext);
    else if (opc inside {opcLw, opcSw, opcBeq, opcBne})
      expectEq("out.ext", {{16{imm[15]}}, imm}, out.ext);
    // Destination by instruction format
    if (opc == opcSpecial && (fn == fnAddu || fn == fnSubu)) a3Exp = instr[15:11];
    else if (opc inside {opcOri, opcLui, opcLw}) a3Exp = instr[20:16];
    else if (opc == opcJal) a3Exp = 5'd31;
    expectEq("out.a3", {27'd0, a3Exp}, {27'd0, out.a3});
    if (opc == opcJ || opc == opcJal) begin
      take = 1'b1;
      tgt  = {pc4[31:28], instr[25:0], 2'b00};
    end else if (opc == opcSpecial && fn == fnJr) begin
      take = 1'b1;
      tgt  = a;
    end else if (opc == opcBeq || opc == opcBne) begin
      take = (a == b) ^ (opc == opcBne);
      tgt  = pc4 + {{14{imm[15]}}, imm, 2'b00};
    end
    expectEq("out.redirect", {31'd0, take}, {31'd0, out.redirect});
    if (take) expectEq("out.nextPc", tgt, out.nextPc);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and settle
  //////////////////////////////////////////////////////////////////////

  // Drive at the rising edge and check at the falling one
  task automatic step(input logic [31:0] ins, input stageInfo ms, input stageInfo ws,
                      input wbPort w);
    @(posedge clk);
    instr    <= ins;
    memStage <= ms;
    wbStage  <= ws;
    wb       <= w;
    pc4      <= randBits(32) & 32'hFFFF_FFFC;
    @(negedge clk);
    checkOutputs();
    // Write lands at the coming edge
    if (w.writeEn && w.addr != 5'd0) regModel[w.addr] = w.data;
  endtask

  task automatic waitSettled();
    int cycles;
    cycles = 0;
    while (out.redirect !== 1'b0 || out.v1 !== '0) begin
      if (cycles == 20) begin
        $display("Timed out waiting for a quiet no-op after reset");
        $display("Test failures found");
        $fatal(1, "Settle timeout");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  initial begin
    stageInfo    idle;
    wbPort       noWrite;
    wbPort       w;
    logic [31:0] ins;
    logic [31:0] r;
    logic [4:0]  ra;
    idle     = '0;
    noWrite  = '0;
    lfsr     = 32'd58;
    arstN    = 1'b0;
    instr    = '0;
    pc4      = '0;
    memStage = '0;
    wbStage  = '0;
    wb       = '0;
    for (int i = 0; i < 32; i++) regModel[i] = '0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    waitSettled();
    // Idle inputs seen at the first edge out of reset
    checkOutputs();

    // Fresh file reads zero everywhere
    for (int i = 0; i < 32; i++) begin
      ra = i[4:0];
      step({opcSpecial, ra, ~ra, 5'd1, 5'd0, fnAddu}, idle, idle, noWrite);
    end
    // r0 ignores writes
    w = {1'b1, 5'd0, 32'hDEAD_BEEF};
    step({opcSpecial, 5'd0, 5'd0, 5'd2, 5'd0, fnAddu}, idle, idle, w);
    step({opcSpecial, 5'd0, 5'd0, 5'd2, 5'd0, fnAddu}, idle, idle, noWrite);

    // Write-through on rs and a normal read on rt next cycle
    for (int i = 1; i < 32; i++) begin
      ra = i[4:0];
      w  = {1'b1, ra, randBits(32)};
      step({opcSpecial, ra, 5'd0, 5'd3, 5'd0, fnSubu}, idle, idle, w);
      step({opcBeq, 5'd0, ra, 16'h0010}, idle, idle, noWrite);
    end

    // Random mix with forwarding and writes
    for (int n = 0; n < 600; n++) begin
      ins = randInstr();
      r   = randBits(7);
      w   = noWrite;
      if (r[0]) begin
        w.writeEn = 1'b1;
        w.addr    = r[1] ? ins[25:21] : r[6:2];
        w.data    = randBits(32);
      end
      step(ins, randStage(ins), randStage(ins), w);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: tests/decodeStage_props.sv
`timescale 1ns/1ps

module decodeStage_props (
  input logic                          clk,
  input logic                          arstN,
  input logic [mipsPkg::dataWidth-1:0] instr,
  input logic [mipsPkg::dataWidth-1:0] pc4,
  input mipsPkg::stageInfo             memStage,
  input mipsPkg::stageInfo             wbStage,
  input mipsPkg::decodeOut             out
);

  import mipsPkg::*;

  logic [5:0]              opc;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;

  assign opc = instr[31:26];
  assign rs  = instr[25:21];
  assign rt  = instr[20:16];

  //////////////////////////////////////////////////////////////////////
  // Operand sources
  //////////////////////////////////////////////////////////////////////

  // r0 is never forwarded and reads as zero
  zeroRs: assert property (@(posedge clk) disable iff (!arstN)
    rs == '0 |-> out.v1 == '0) else $error("v1 not zero for rs of r0");

  // Memory stage is the newest result
  memFwdRs: assert property (@(posedge clk) disable iff (!arstN)
    (rs != '0 && memStage.valid && memStage.dest == rs) |->
      out.v1 == (memStage.isPc8 ? memStage.other : memStage.alu))
    else $error("v1 not taken from the memory stage");

  // Writeback only when memory misses
  wbFwdRt: assert property (@(posedge clk) disable iff (!arstN)
    (rt != '0 && !(memStage.valid && memStage.dest == rt) &&
     wbStage.valid && wbStage.dest == rt) |->
      out.v2 == (wbStage.isMem ? wbStage.other : wbStage.alu))
    else $error("v2 not taken from the writeback stage");

  //////////////////////////////////////////////////////////////////////
  // Immediate and control flow
  //////////////////////////////////////////////////////////////////////

  luiUpper: assert property (@(posedge clk) disable iff (!arstN)
    opc == opcLui |-> out.ext == {instr[15:0], 16'h0000})
    else $error("lui immediate not on top");

  linkPc: assert property (@(posedge clk) disable iff (!arstN)
    out.pc8 == pc4 + 32'd4) else $error("pc8 not pc4 plus four");

  // j and jal always leave for the region target
  jumpTarget: assert property (@(posedge clk) disable iff (!arstN)
    (opc == opcJ || opc == opcJal) |->
      (out.redirect && out.nextPc == {pc4[31:28], instr[25:0], 2'b00}))
    else $error("jump target or redirect wrong");

  beqTaken: assert property (@(posedge clk) disable iff (!arstN)
    opc == opcBeq |-> out.redirect == (out.v1 == out.v2))
    else $error("beq redirect does not follow the compare");

endmodule

bind decodeStage decodeStage_props i_props (
  .clk      (clk),
  .arstN    (arstN),
  .instr    (instr),
  .pc4      (pc4),
  .memStage (memStage),
  .wbStage  (wbStage),
  .out      (out)
);

// File: hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [mipsPkg::dataWidth-1:0] instr,
  input  logic [mipsPkg::dataWidth-1:0] pc4,
  input  mipsPkg::stageInfo             memStage,
  input  mipsPkg::stageInfo             wbStage,
  input  mipsPkg::wbPort                wb,
  output mipsPkg::decodeOut             out
);

  import mipsPkg::*;

  // Control from decoder
  ctrlBus ctrl;

  // Raw register reads
  logic [dataWidth-1:0] rd1;
  logic [dataWidth-1:0] rd2;

  // Datapath results
  logic [dataWidth-1:0]    v1;
  logic [dataWidth-1:0]    v2;
  logic [dataWidth-1:0]    ext;
  logic [regAddrWidth-1:0] a3;
  logic [dataWidth-1:0]    pc8;
  logic                    redirect;
  logic [dataWidth-1:0]    nextPc;

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  decodeCtrl uDecodeCtrl (
    .instr    (instr),
    .memStage (memStage),
    .wbStage  (wbStage),
    .ctrl     (ctrl)
  );

  // rs and rt fields address the file
  regFile uRegFile (
    .clk   (clk),
    .arstN (arstN),
    .ra1   (instr[25:21]),
    .ra2   (instr[20:16]),
    .wb    (wb),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  operandPrep uOperandPrep (
    .ctrl     (ctrl),
    .instr    (instr),
    .pc4      (pc4),
    .rd1      (rd1),
    .rd2      (rd2),
    .memStage (memStage),
    .wbStage  (wbStage),
    .v1       (v1),
    .v2       (v2),
    .ext      (ext),
    .a3       (a3),
    .pc8      (pc8)
  );

  // Compares the forwarded operands
  branchUnit uBranchUnit (
    .ctrl     (ctrl),
    .pc4      (pc4),
    .instr    (instr),
    .v1       (v1),
    .v2       (v2),
    .redirect (redirect),
    .nextPc   (nextPc)
  );

  // Result bundle
  assign out = '{v1: v1, v2: v2, ext: ext, a3: a3, pc8: pc8,
                 redirect: redirect, nextPc: nextPc};

endmodule

// File: hdl/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
  input  mipsPkg::ctrlBus               ctrl,
  input  logic [mipsPkg::dataWidth-1:0] pc4,
  input  logic [mipsPkg::dataWidth-1:0] instr,
  input  logic [mipsPkg::dataWidth-1:0] v1,
  input  logic [mipsPkg::dataWidth-1:0] v2,
  output logic                          redirect,
  output logic [mipsPkg::dataWidth-1:0] nextPc
);

  import mipsPkg::*;

  logic                 cmpHit;
  logic                 takeBranch;
  logic [dataWidth-1:0] branchOff;
  logic [dataWidth-1:0] branchTgt;
  logic [dataWidth-1:0] jumpTgt;

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  // Compare sees the forwarded operands
  always_comb begin
    case (ctrl.cmp)
      cmpNe:   cmpHit = (v1 != v2);
      default: cmpHit = (v1 == v2);
    endcase
  end

  // Only meaningful for beq and bne
  assign takeBranch = ctrl.isBranch && cmpHit;

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  // Sign-extended word offset
  assign branchOff = {{14{instr[15]}}, instr[15:0], 2'b00};
  assign branchTgt = pc4 + branchOff;

  // Region of the delay slot PC
  assign jumpTgt = {pc4[31:28], instr[25:0], 2'b00};

  always_comb begin
    case (ctrl.npc)
      npcJump: nextPc = jumpTgt;
      // jr target
      npcReg:  nextPc = v1;
      default: nextPc = branchTgt;
    endcase
  end

  // Jumps always leave and branches follow the compare
  assign redirect = ctrl.isJump || takeBranch;

endmodule

// File: hdl/operandPrep.sv
`timescale 1ns/1ps

module operandPrep (
  input  mipsPkg::ctrlBus                  ctrl,
  input  logic [mipsPkg::dataWidth-1:0]    instr,
  input  logic [mipsPkg::dataWidth-1:0]    pc4,
  input  logic [mipsPkg::dataWidth-1:0]    rd1,
  input  logic [mipsPkg::dataWidth-1:0]    rd2,
  input  mipsPkg::stageInfo                memStage,
  input  mipsPkg::stageInfo                wbStage,
  output logic [mipsPkg::dataWidth-1:0]    v1,
  output logic [mipsPkg::dataWidth-1:0]    v2,
  output logic [mipsPkg::dataWidth-1:0]    ext,
  output logic [mipsPkg::regAddrWidth-1:0] a3,
  output logic [mipsPkg::dataWidth-1:0]    pc8
);

  import mipsPkg::*;

  logic [15:0] imm;

  assign imm = instr[15:0];

  //////////////////////////////////////////////////////////////////////
  // Forwarding muxes
  //////////////////////////////////////////////////////////////////////

  // Five-way operand select
  function automatic logic [dataWidth-1:0] fwdMux(
    input fwdSel                sel,
    input logic [dataWidth-1:0] rd,
    input stageInfo             mem,
    input stageInfo             wb
  );
    logic [dataWidth-1:0] val;
    case (sel)
      fwdMemAlu: val = mem.alu;
      fwdMemPc8: val = mem.other;
      fwdWbAlu:  val = wb.alu;
      fwdWbMem:  val = wb.other;
      default:   val = rd;
    endcase
    return val;
  endfunction

  assign v1 = fwdMux(ctrl.fwdRs, rd1, memStage, wbStage);
  assign v2 = fwdMux(ctrl.fwdRt, rd2, memStage, wbStage);

  //////////////////////////////////////////////////////////////////////
  // Immediate and destination
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.ext)
      extSign:  ext = {{16{imm[15]}}, imm};
      // lui places halfword on top
      extUpper: ext = {imm, 16'h0000};
      default:  ext = {16'h0000, imm};
    endcase
  end

  always_comb begin
    case (ctrl.dest)
      destRt:   a3 = instr[20:16];
      destRd:   a3 = instr[15:11];
      destLink: a3 = linkReg;
      // No write back
      default:  a3 = '0;
    endcase
  end

  // Link value for jal
  assign pc8 = pc4 + 32'd4;

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [mipsPkg::regAddrWidth-1:0] ra1,
  input  logic [mipsPkg::regAddrWidth-1:0] ra2,
  input  mipsPkg::wbPort                   wb,
  output logic [mipsPkg::dataWidth-1:0]    rd1,
  output logic [mipsPkg::dataWidth-1:0]    rd2
);

  import mipsPkg::*;

  // r0 has no storage
  logic [dataWidth-1:0] regs [1:31];

  // Write port drops r0 writes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.writeEn && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // One read port
  // Same-cycle write is passed through
  function automatic logic [dataWidth-1:0] readPort(
    input logic [regAddrWidth-1:0] ra
  );
    logic [dataWidth-1:0] val;
    if (ra == '0) begin
      val = '0;
    end else if (wb.writeEn && wb.addr == ra) begin
      val = wb.data;
    end else begin
      val = regs[ra];
    end
    return val;
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

// File: hdl/decodeCtrl.sv
`timescale 1ns/1ps

module decodeCtrl (
  input  logic [mipsPkg::dataWidth-1:0] instr,
  input  mipsPkg::stageInfo             memStage,
  input  mipsPkg::stageInfo             wbStage,
  output mipsPkg::ctrlBus               ctrl
);

  import mipsPkg::*;

  // Instruction fields
  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  opKind                   kind;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];

  //////////////////////////////////////////////////////////////////////
  // Forwarding priority
  //////////////////////////////////////////////////////////////////////

  // Newest result wins and r0 is never forwarded
  function automatic fwdSel pickFwd(
    input logic [regAddrWidth-1:0] src,
    input stageInfo                mem,
    input stageInfo                wb
  );
    fwdSel sel;
    sel = fwdReg;
    if (src != '0) begin
      if (mem.valid && mem.dest == src) begin
        // jal in mem carries its link value
        sel = mem.isPc8 ? fwdMemPc8 : fwdMemAlu;
      end else if (wb.valid && wb.dest == src) begin
        // Load result vs ALU result
        sel = wb.isMem ? fwdWbMem : fwdWbAlu;
      end
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opcode)
      opcSpecial: begin
        case (funct)
          fnAddu:  kind = opAddu;
          fnSubu:  kind = opSubu;
          fnJr:    kind = opJr;
          default: kind = opNop;
        endcase
      end
      opcOri:  kind = opOri;
      opcLui:  kind = opLui;
      opcLw:   kind = opLw;
      opcSw:   kind = opSw;
      opcBeq:  kind = opBeq;
      opcBne:  kind = opBne;
      opcJ:    kind = opJ;
      opcJal:  kind = opJal;
      // Anything else is a no-op
      default: kind = opNop;
    endcase
  end

  // Control fields from the decoded kind
  always_comb begin
    // Defaults describe a no-op
    ctrl.ext      = extZero;
    ctrl.npc      = npcBranch;
    ctrl.cmp      = cmpEq;
    ctrl.dest     = destNone;
    ctrl.isBranch = 1'b0;
    ctrl.isJump   = 1'b0;
    case (kind)
      opAddu, opSubu: ctrl.dest = destRd;
      opOri: begin
        ctrl.ext  = extZero;
        ctrl.dest = destRt;
      end
      opLui: begin
        ctrl.ext  = extUpper;
        ctrl.dest = destRt;
      end
      opLw: begin
        ctrl.ext  = extSign;
        ctrl.dest = destRt;
      end
      // Store needs the offset but no destination
      opSw: ctrl.ext = extSign;
      opBeq, opBne: begin
        ctrl.ext      = extSign;
        ctrl.npc      = npcBranch;
        ctrl.cmp      = (kind == opBne) ? cmpNe : cmpEq;
        ctrl.isBranch = 1'b1;
      end
      opJ, opJal: begin
        ctrl.npc    = npcJump;
        ctrl.isJump = 1'b1;
        // Only jal links
        ctrl.dest   = (kind == opJal) ? destLink : destNone;
      end
      opJr: begin
        ctrl.npc    = npcReg;
        ctrl.isJump = 1'b1;
      end
      default: ;
    endcase
    // Selectors per source register
    ctrl.fwdRs = pickFwd(rs, memStage, wbStage);
    ctrl.fwdRt = pickFwd(rt, memStage, wbStage);
  end

endmodule

// File: hdl/mipsPkg.sv
package mipsPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and fixed registers
  //////////////////////////////////////////////////////////////////////

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  // jal link target
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // Primary opcode field values
  localparam logic [5:0] opcSpecial = 6'h00;
  localparam logic [5:0] opcJ       = 6'h02;
  localparam logic [5:0] opcJal     = 6'h03;
  localparam logic [5:0] opcBeq     = 6'h04;
  localparam logic [5:0] opcBne     = 6'h05;
  localparam logic [5:0] opcOri     = 6'h0d;
  localparam logic [5:0] opcLui     = 6'h0f;
  localparam logic [5:0] opcLw      = 6'h23;
  localparam logic [5:0] opcSw      = 6'h2b;

  // Function field values under opcSpecial
  localparam logic [5:0] fnJr   = 6'h08;
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSubu = 6'h23;

  //////////////////////////////////////////////////////////////////////
  // Decode enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    opNop, opAddu, opSubu, opOri, opLui, opLw,
    opSw, opBeq, opBne, opJ, opJal, opJr
  } opKind;

  typedef enum logic [1:0] {extZero, extSign, extUpper} extMode;
  typedef enum logic [1:0] {npcBranch, npcJump, npcReg} npcMode;
  typedef enum logic {cmpEq, cmpNe} cmpMode;
  typedef enum logic [1:0] {destRt, destRd, destLink, destNone} destMode;

  // Operand sources, register file first
  typedef enum logic [2:0] {
    fwdReg, fwdMemAlu, fwdMemPc8, fwdWbAlu, fwdWbMem
  } fwdSel;

  //////////////////////////////////////////////////////////////////////
  // Structs shared with the testbench
  //////////////////////////////////////////////////////////////////////

  // Result of one later stage
  typedef struct packed {
    logic                    valid;
    logic [regAddrWidth-1:0] dest;
    logic                    isPc8;
    logic                    isMem;
    logic [dataWidth-1:0]    alu;
    // PC+8 in mem and load data in wb
    logic [dataWidth-1:0]    other;
  } stageInfo;

  typedef struct packed {
    logic                    writeEn;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wbPort;

  typedef struct packed {
    extMode  ext;
    npcMode  npc;
    cmpMode  cmp;
    destMode dest;
    logic    isBranch;
    logic    isJump;
    fwdSel   fwdRs;
    fwdSel   fwdRt;
  } ctrlBus;

  typedef struct packed {
    logic [dataWidth-1:0]    v1;
    logic [dataWidth-1:0]    v2;
    logic [dataWidth-1:0]    ext;
    logic [regAddrWidth-1:0] a3;
    logic [dataWidth-1:0]    pc8;
    logic                    redirect;
    logic [dataWidth-1:0]    nextPc;
  } decodeOut;

endpackage
